//--- include/dcfifo_defines.svh
/*
 * Width and depth settings for the dual-clock streaming FIFO.
 * Included by the package and by any RTL that sizes ports or arrays.
 */
`ifndef DCFIFO_DEFINES_SVH
`define DCFIFO_DEFINES_SVH

// Stream data, one byte per beat
`define DCFIFO_DATA_WIDTH 8

// 16 entries
`define DCFIFO_ADDR_WIDTH 4

// Flip-flops in each pointer synchronizer
`define DCFIFO_SYNC_STAGES 2

// CSR word and the level fields inside it
`define DCFIFO_CSR_WIDTH 32
`define DCFIFO_LEVEL_WIDTH 24

`endif

//--- hdl/dcfifo_pkg.sv
/*
 * Types shared by the FIFO blocks and the Gray code helpers used
 * for the pointer crossing. Import with dcfifo_pkg::* in the module header.
 */
package dcfifo_pkg;

`include "dcfifo_defines.svh"

    localparam int PTR_MSB = `DCFIFO_ADDR_WIDTH;

    // One stream beat as stored in the memory
    typedef struct packed {
        logic                          startofpacket;
        logic                          endofpacket;
        logic [`DCFIFO_DATA_WIDTH-1:0] data;
    } payload_t;

    typedef logic [`DCFIFO_ADDR_WIDTH-1:0]  addr_t;
    // Extra MSB separates full from empty
    typedef logic [`DCFIFO_ADDR_WIDTH:0]    ptr_t;
    typedef logic [`DCFIFO_LEVEL_WIDTH-1:0] level_t;
    typedef logic [`DCFIFO_CSR_WIDTH-1:0]   csr_data_t;

    typedef enum logic {
        CSR_FILL_LEVEL = 1'b0,
        CSR_THRESHOLD  = 1'b1
    } csr_addr_e;

    // Direction of the threshold test
    typedef enum logic {
        CMP_AT_LEAST,
        CMP_AT_MOST
    } level_cmp_e;

    function automatic ptr_t bin2gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic ptr_t gray2bin(ptr_t gray);
        ptr_t bin;
        bin[PTR_MSB] = gray[PTR_MSB];
        for (int i = PTR_MSB - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

//--- hdl/dcfifo_csr_if.sv
/*
 * Two-register CSR bus. The top level drives the master side from its
 * plain ports and each level/threshold block sits on the slave side.
 */
`timescale 1ns/1ps
`include "dcfifo_defines.svh"

interface dcfifo_csr_if;

    logic                         address;
    logic                         read;
    logic                         write;
    logic [`DCFIFO_CSR_WIDTH-1:0] writedata;
    // Registered, valid the cycle after read
    logic [`DCFIFO_CSR_WIDTH-1:0] readdata;

    modport master (output address, read, write, writedata, input readdata);

    modport slave (input address, read, write, writedata, output readdata);

endinterface

//--- hdl/dcfifo_ptr_sync.sv
/*
 * Carries a FIFO pointer into the other clock domain. The pointer is
 * registered as Gray code at the source, then hardened by a flop chain.
 */
`timescale 1ns/1ps
`include "dcfifo_defines.svh"

module dcfifo_ptr_sync import dcfifo_pkg::*; (
    input  logic src_clk,
    input  logic src_reset_n,
    input  logic dst_clk,
    input  logic dst_reset_n,
    input  ptr_t src_ptr,
    output ptr_t dst_ptr
);

    localparam int STAGES = `DCFIFO_SYNC_STAGES;

    ptr_t src_gray;
    ptr_t sync_q [STAGES];

    // Only one bit may move between two samples at the far side
    always_ff @(posedge src_clk or negedge src_reset_n) begin
        if (!src_reset_n) begin
            src_gray <= '0;
        end else begin
            src_gray <= bin2gray(src_ptr);
        end
    end

    // --------------------------------------------------
    // Destination flop chain
    // --------------------------------------------------
    always_ff @(posedge dst_clk or negedge dst_reset_n) begin
        if (!dst_reset_n) begin
            foreach (sync_q[i]) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= src_gray;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign dst_ptr = gray2bin(sync_q[STAGES-1]);

endmodule

//--- hdl/dcfifo_ram.sv
/*
 * Simple dual-port payload memory. Written on in_clk, read on out_clk
 * with one registered cycle of latency.
 */
`timescale 1ns/1ps
`include "dcfifo_defines.svh"

module dcfifo_ram import dcfifo_pkg::*; (
    input  logic     in_clk,
    input  logic     out_clk,
    input  logic     wr_en,
    input  addr_t    wr_addr,
    input  payload_t wr_data,
    input  addr_t    rd_addr,
    output payload_t rd_data
);

    localparam int DEPTH = 1 << `DCFIFO_ADDR_WIDTH;

    payload_t mem [DEPTH];

    always_ff @(posedge in_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge out_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hdl/dcfifo_write_ctrl.sv
/*
 * Write side control. Advances the write pointer on accepted beats and
 * registers the full flag and the input fill level against the read pointer.
 */
`timescale 1ns/1ps

module dcfifo_write_ctrl import dcfifo_pkg::*; (
    input  logic   in_clk,
    input  logic   in_reset_n,
    input  logic   in_valid,
    input  ptr_t   rd_ptr,
    output logic   in_ready,
    output logic   wr_en,
    output ptr_t   wr_ptr,
    output level_t fill_level
);

    localparam int AW = $bits(addr_t);

    ptr_t wr_ptr_next;
    ptr_t fill_next;
    logic full;

    assign in_ready = !full;
    assign wr_en    = in_valid && in_ready;

    assign wr_ptr_next = wr_ptr + ptr_t'(wr_en);
    // Modulo pointer distance, never more than the depth
    assign fill_next   = wr_ptr_next - rd_ptr;

    // --------------------------------------------------
    // Pointer, full flag, fill level
    // --------------------------------------------------
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_ptr     <= '0;
            full       <= 1'b0;
            fill_level <= '0;
        end else begin
            wr_ptr     <= wr_ptr_next;
            // Same slot, opposite lap
            full       <= (wr_ptr_next[AW-1:0] == rd_ptr[AW-1:0]) &&
                          (wr_ptr_next[AW] != rd_ptr[AW]);
            fill_level <= level_t'(fill_next);
        end
    end

endmodule

//--- hdl/dcfifo_read_ctrl.sv
/*
 * Read side control with the registered output stage. The memory is
 * addressed with the next read pointer so its registered read lines up
 * with the stage load.
 */
`timescale 1ns/1ps

module dcfifo_read_ctrl import dcfifo_pkg::*; (
    input  logic     out_clk,
    input  logic     out_reset_n,
    input  logic     out_ready,
    input  ptr_t     wr_ptr,
    input  payload_t rd_data,
    output ptr_t     rd_ptr,
    output addr_t    rd_addr,
    output payload_t out_payload,
    output logic     out_valid,
    output level_t   fill_level
);

    ptr_t rd_ptr_next;
    ptr_t mem_fill_next;
    ptr_t mem_fill;
    logic empty;
    logic load;

    // Stage takes a beat when empty or when the sink drains it
    assign load = out_ready || !out_valid;

    assign rd_ptr_next   = rd_ptr + ptr_t'(load && !empty);
    assign rd_addr       = addr_t'(rd_ptr_next);
    assign mem_fill_next = wr_ptr - rd_ptr_next;

    // --------------------------------------------------
    // Pointer, empty flag, memory fill
    // --------------------------------------------------
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            rd_ptr   <= '0;
            empty    <= 1'b1;
            mem_fill <= '0;
        end else begin
            rd_ptr   <= rd_ptr_next;
            empty    <= (rd_ptr_next == wr_ptr);
            mem_fill <= mem_fill_next;
        end
    end

    // --------------------------------------------------
    // Output stage
    // --------------------------------------------------
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= !empty;
        end
    end

    always_ff @(posedge out_clk) begin
        if (load) begin
            out_payload <= rd_data;
        end
    end

    // Counts the output stage too, so a full FIFO reads 17
    assign fill_level = level_t'(mem_fill) + level_t'(out_valid);

endmodule

//--- hdl/dcfifo_level_csr.sv
/*
 * Threshold register and CSR read-back for one side of the FIFO, plus the
 * streamed status bit. CMP selects almost full or almost empty behaviour.
 */
`timescale 1ns/1ps

module dcfifo_level_csr import dcfifo_pkg::*; #(
    parameter level_cmp_e CMP = CMP_AT_LEAST
) (
    input  logic              clk,
    input  logic              reset_n,
    input  level_t            fill_level,
    dcfifo_csr_if.slave       csr,
    output logic              status_valid,
    output logic              status_data
);

    level_t    threshold;
    csr_addr_e addr;
    logic      level_hit;

    assign addr = csr_addr_e'(csr.address);

    // --------------------------------------------------
    // CSR access, write wins over read
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            threshold   <= '0;
            csr.readdata <= '0;
        end else if (csr.write) begin
            if (addr == CSR_THRESHOLD) begin
                threshold <= level_t'(csr.writedata);
            end
        end else if (csr.read) begin
            // Upper byte reads zero through the extension
            case (addr)
                CSR_FILL_LEVEL: csr.readdata <= csr_data_t'(fill_level);
                CSR_THRESHOLD:  csr.readdata <= csr_data_t'(threshold);
                default:        csr.readdata <= '0;
            endcase
        end
    end

    assign level_hit = (CMP == CMP_AT_LEAST) ? (fill_level >= threshold)
                                             : (fill_level <= threshold);

    // Status goes valid one cycle out of reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            status_valid <= 1'b0;
            status_data  <= 1'b0;
        end else begin
            status_valid <= 1'b1;
            status_data  <= level_hit;
        end
    end

endmodule

//--- hdl/dcfifo_top.sv
/*
 * Dual-clock streaming FIFO top level with plain ports. Wires the write
 * domain (in_clk) and read domain (out_clk) blocks and their CSR buses.
 */
`timescale 1ns/1ps
`include "dcfifo_defines.svh"

module dcfifo_top import dcfifo_pkg::*; (
    input  logic                          in_clk,
    input  logic                          in_reset_n,
    input  logic                          out_clk,
    input  logic                          out_reset_n,

    // Sink
    input  logic [`DCFIFO_DATA_WIDTH-1:0] in_data,
    input  logic                          in_valid,
    input  logic                          in_startofpacket,
    input  logic                          in_endofpacket,
    output logic                          in_ready,

    // Source
    output logic [`DCFIFO_DATA_WIDTH-1:0] out_data,
    output logic                          out_valid,
    output logic                          out_startofpacket,
    output logic                          out_endofpacket,
    input  logic                          out_ready,

    // CSR ports
    input  logic                          in_csr_address,
    input  logic                          in_csr_read,
    input  logic                          in_csr_write,
    input  csr_data_t                     in_csr_writedata,
    output csr_data_t                     in_csr_readdata,
    input  logic                          out_csr_address,
    input  logic                          out_csr_read,
    input  logic                          out_csr_write,
    input  csr_data_t                     out_csr_writedata,
    output csr_data_t                     out_csr_readdata,

    // Streamed status
    output logic                          almost_full_valid,
    output logic                          almost_full_data,
    output logic                          almost_empty_valid,
    output logic                          almost_empty_data
);

    payload_t in_payload;
    payload_t out_payload;
    payload_t rd_data;
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    ptr_t     wr_ptr_sync;
    ptr_t     rd_ptr_sync;
    addr_t    rd_addr;
    logic     wr_en;
    level_t   in_fill_level;
    level_t   out_fill_level;

    dcfifo_csr_if in_csr ();
    dcfifo_csr_if out_csr ();

    // --------------------------------------------------
    // Port packing
    // --------------------------------------------------
    assign in_payload = '{startofpacket: in_startofpacket,
                          endofpacket:   in_endofpacket,
                          data:          in_data};

    assign out_data          = out_payload.data;
    assign out_startofpacket = out_payload.startofpacket;
    assign out_endofpacket   = out_payload.endofpacket;

    assign in_csr.address   = in_csr_address;
    assign in_csr.read      = in_csr_read;
    assign in_csr.write     = in_csr_write;
    assign in_csr.writedata = in_csr_writedata;
    assign in_csr_readdata  = in_csr.readdata;

    assign out_csr.address   = out_csr_address;
    assign out_csr.read      = out_csr_read;
    assign out_csr.write     = out_csr_write;
    assign out_csr.writedata = out_csr_writedata;
    assign out_csr_readdata  = out_csr.readdata;

    // --------------------------------------------------
    // Write domain
    // --------------------------------------------------
    dcfifo_write_ctrl write_ctrl_i (
        .in_clk     (in_clk),
        .in_reset_n (in_reset_n),
        .in_valid   (in_valid),
        .rd_ptr     (rd_ptr_sync),
        .in_ready   (in_ready),
        .wr_en      (wr_en),
        .wr_ptr     (wr_ptr),
        .fill_level (in_fill_level)
    );

    dcfifo_level_csr #(.CMP(CMP_AT_LEAST)) in_level_csr_i (
        .clk          (in_clk),
        .reset_n      (in_reset_n),
        .fill_level   (in_fill_level),
        .csr          (in_csr.slave),
        .status_valid (almost_full_valid),
        .status_data  (almost_full_data)
    );

    dcfifo_ram ram_i (
        .in_clk  (in_clk),
        .out_clk (out_clk),
        .wr_en   (wr_en),
        .wr_addr (addr_t'(wr_ptr)),
        .wr_data (in_payload),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Pointer crossings, one per direction
    dcfifo_ptr_sync wr_ptr_sync_i (
        .src_clk     (in_clk),
        .src_reset_n (in_reset_n),
        .dst_clk     (out_clk),
        .dst_reset_n (out_reset_n),
        .src_ptr     (wr_ptr),
        .dst_ptr     (wr_ptr_sync)
    );

    dcfifo_ptr_sync rd_ptr_sync_i (
        .src_clk     (out_clk),
        .src_reset_n (out_reset_n),
        .dst_clk     (in_clk),
        .dst_reset_n (in_reset_n),
        .src_ptr     (rd_ptr),
        .dst_ptr     (rd_ptr_sync)
    );

    // --------------------------------------------------
    // Read domain
    // --------------------------------------------------
    dcfifo_read_ctrl read_ctrl_i (
        .out_clk     (out_clk),
        .out_reset_n (out_reset_n),
        .out_ready   (out_ready),
        .wr_ptr      (wr_ptr_sync),
        .rd_data     (rd_data),
        .rd_ptr      (rd_ptr),
        .rd_addr     (rd_addr),
        .out_payload (out_payload),
        .out_valid   (out_valid),
        .fill_level  (out_fill_level)
    );

    dcfifo_level_csr #(.CMP(CMP_AT_MOST)) out_level_csr_i (
        .clk          (out_clk),
        .reset_n      (out_reset_n),
        .fill_level   (out_fill_level),
        .csr          (out_csr.slave),
        .status_valid (almost_empty_valid),
        .status_data  (almost_empty_data)
    );

endmodule

//--- test/dcfifo_assertions.sv
/*
 * Concurrent checks on the FIFO stream and status outputs.
 * Attached to every dcfifo_top instance through the bind below.
 */
`timescale 1ns/1ps
`include "dcfifo_defines.svh"

module dcfifo_assertions import dcfifo_pkg::*; (
    input logic                          in_clk,
    input logic                          in_reset_n,
    input logic                          out_clk,
    input logic                          out_reset_n,
    input logic                          wr_en,
    input ptr_t                          wr_ptr,
    input ptr_t                          rd_ptr_sync,
    input logic                          out_valid,
    input logic                          out_ready,
    input logic                          out_startofpacket,
    input logic                          out_endofpacket,
    input logic [`DCFIFO_DATA_WIDTH-1:0] out_data,
    input logic                          almost_full_valid,
    input logic                          almost_empty_valid
);

    localparam int DEPTH = 1 << `DCFIFO_ADDR_WIDTH;

    // Failed assertion count for the end-of-run summary
    int failures = 0;

    // A stalled beat keeps its valid and its payload
    stalled_beat_stable: assert property (
        @(posedge out_clk) disable iff (!out_reset_n)
        out_valid && !out_ready |=>
            out_valid && $stable({out_startofpacket, out_endofpacket, out_data})
    ) else begin
        failures++;
        $error("output beat changed while stalled");
    end

    // No write may land while the memory is full
    no_write_when_full: assert property (
        @(posedge in_clk) disable iff (!in_reset_n)
        wr_en |-> (ptr_t'(wr_ptr - rd_ptr_sync) < DEPTH)
    ) else begin
        failures++;
        $error("write landed on a full memory");
    end

    // Status valids are sticky once out of reset
    full_status_sticky: assert property (
        @(posedge in_clk) disable iff (!in_reset_n)
        almost_full_valid |=> almost_full_valid
    ) else begin
        failures++;
        $error("almost_full_valid fell");
    end

    empty_status_sticky: assert property (
        @(posedge out_clk) disable iff (!out_reset_n)
        almost_empty_valid |=> almost_empty_valid
    ) else begin
        failures++;
        $error("almost_empty_valid fell");
    end

endmodule

bind dcfifo_top dcfifo_assertions dcfifo_assertions_i (
    .in_clk             (in_clk),
    .in_reset_n         (in_reset_n),
    .out_clk            (out_clk),
    .out_reset_n        (out_reset_n),
    .wr_en              (wr_en),
    .wr_ptr             (wr_ptr),
    .rd_ptr_sync        (rd_ptr_sync),
    .out_valid          (out_valid),
    .out_ready          (out_ready),
    .out_startofpacket  (out_startofpacket),
    .out_endofpacket    (out_endofpacket),
    .out_data           (out_data),
    .almost_full_valid  (almost_full_valid),
    .almost_empty_valid (almost_empty_valid)
);

//--- test/dcfifo_tb.sv
/*
 * Directed testbench for the dual-clock streaming FIFO. Runs reset,
 * ordered transfer, back-pressure, CSR and status tests, then reports.
 */
`timescale 1ns/1ps
`include "dcfifo_defines.svh"

module dcfifo_tb import dcfifo_pkg::*; ();

    localparam int DRIVE_DELAY = 10;
    // About 300 in_clk cycles of tests, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] SEED = 32'h1a48fb6f;

    logic                          in_clk;
    logic                          in_reset_n;
    logic                          out_clk;
    logic                          out_reset_n;
    logic [`DCFIFO_DATA_WIDTH-1:0] in_data;
    logic                          in_valid;
    logic                          in_startofpacket;
    logic                          in_endofpacket;
    logic                          in_ready;
    logic [`DCFIFO_DATA_WIDTH-1:0] out_data;
    logic                          out_valid;
    logic                          out_startofpacket;
    logic                          out_endofpacket;
    logic                          out_ready;
    logic                          in_csr_address;
    logic                          in_csr_read;
    logic                          in_csr_write;
    csr_data_t                     in_csr_writedata;
    csr_data_t                     in_csr_readdata;
    logic                          out_csr_address;
    logic                          out_csr_read;
    logic                          out_csr_write;
    csr_data_t                     out_csr_writedata;
    csr_data_t                     out_csr_readdata;
    logic                          almost_full_valid;
    logic                          almost_full_data;
    logic                          almost_empty_valid;
    logic                          almost_empty_data;

    logic [31:0] rng_state;
    payload_t    beats[$];
    int          error_count;
    int          check_count_total;
    int          tests_run;
    int          cycle_count;

    dcfifo_top dcfifo_top_i (.*);

    always #50 in_clk = ~in_clk;
    always #65 out_clk = ~out_clk;

    // --------------------------------------------------
    // Random numbers and compare tasks
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_payload(input string name, input payload_t got, input payload_t exp);
        check_count_total++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s got 0x%03h expected 0x%03h", name, got, exp);
        end
    endtask

    task automatic check_csr(input string name, input csr_data_t got, input csr_data_t exp);
        check_count_total++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count_total++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        check_count_total++;
        if (got != exp) begin
            error_count++;
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            $display("Test %0d %s: FAIL (%0d errors)", tests_run, name,
                     error_count - errors_before);
        end
    endtask

    // --------------------------------------------------
    // Bus drivers
    // --------------------------------------------------
    task automatic make_beats(input int n);
        logic [31:0] r;
        payload_t    p;
        beats.delete();
        for (int i = 0; i < n; i++) begin
            r = next_random();
            p.data          = r[`DCFIFO_DATA_WIDTH-1:0];
            p.startofpacket = (i == 0);
            p.endofpacket   = (i == n - 1);
            beats.push_back(p);
        end
    endtask

    // Holds the beat until the write side takes it
    task automatic send_beat(input payload_t beat);
        logic accepted;
        in_data          = beat.data;
        in_startofpacket = beat.startofpacket;
        in_endofpacket   = beat.endofpacket;
        in_valid         = 1'b1;
        accepted         = 1'b0;
        while (!accepted) begin
            accepted = in_ready;
            @(posedge in_clk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_beats(input int first, input int n);
        @(posedge in_clk);
        #DRIVE_DELAY;
        for (int i = 0; i < n; i++) begin
            send_beat(beats[first + i]);
        end
    endtask

    task automatic receive_beats(input int first, input int n, input bit stall);
        logic [31:0] r;
        payload_t    got_beat;
        int          got;
        got = 0;
        @(posedge out_clk);
        #DRIVE_DELAY;
        while (got < n) begin
            r = stall ? next_random() : 32'h1;
            out_ready = r[0];
            if (out_valid && out_ready) begin
                got_beat = '{startofpacket: out_startofpacket,
                             endofpacket:   out_endofpacket,
                             data:          out_data};
                check_payload("out_payload", got_beat, beats[first + got]);
                got++;
            end
            @(posedge out_clk);
            #DRIVE_DELAY;
        end
        out_ready = 1'b0;
    endtask

    task automatic csr_access(input bit out_side, input bit do_read, input bit do_write,
                              input csr_addr_e addr, input csr_data_t wdata,
                              output csr_data_t rdata);
        if (!out_side) begin
            @(posedge in_clk);
            #DRIVE_DELAY;
            in_csr_address   = addr;
            in_csr_read      = do_read;
            in_csr_write     = do_write;
            in_csr_writedata = wdata;
            @(posedge in_clk);
            #DRIVE_DELAY;
            in_csr_read  = 1'b0;
            in_csr_write = 1'b0;
            rdata        = in_csr_readdata;
        end else begin
            @(posedge out_clk);
            #DRIVE_DELAY;
            out_csr_address   = addr;
            out_csr_read      = do_read;
            out_csr_write     = do_write;
            out_csr_writedata = wdata;
            @(posedge out_clk);
            #DRIVE_DELAY;
            out_csr_read  = 1'b0;
            out_csr_write = 1'b0;
            rdata         = out_csr_readdata;
        end
    endtask

    task automatic csr_write(input bit out_side, input csr_addr_e addr, input csr_data_t wdata);
        csr_data_t unused;
        csr_access(out_side, 1'b0, 1'b1, addr, wdata, unused);
    endtask

    task automatic csr_read(input bit out_side, input csr_addr_e addr, output csr_data_t rdata);
        csr_access(out_side, 1'b1, 1'b0, addr, '0, rdata);
    endtask

    // Waits past the pointer synchronizers and the status registers
    task automatic settle();
        repeat (12) @(posedge in_clk);
        #DRIVE_DELAY;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_values();
        int        errors_before;
        csr_data_t rdata;
        errors_before = error_count;
        fork
            begin
                repeat (5) @(posedge in_clk);
                #DRIVE_DELAY;
                in_reset_n = 1'b1;
                check_bit("in_ready", in_ready, 1'b1);
                check_bit("almost_full_valid", almost_full_valid, 1'b0);
            end
            begin
                repeat (5) @(posedge out_clk);
                #DRIVE_DELAY;
                out_reset_n = 1'b1;
                check_bit("out_valid", out_valid, 1'b0);
                check_bit("almost_empty_valid", almost_empty_valid, 1'b0);
            end
        join
        csr_read(1'b0, CSR_FILL_LEVEL, rdata);
        check_csr("in_csr_readdata", rdata, 32'h0);
        csr_read(1'b1, CSR_FILL_LEVEL, rdata);
        check_csr("out_csr_readdata", rdata, 32'h0);
        report_test("reset values", errors_before);
    endtask

    task automatic test_ordered_transfer();
        int errors_before;
        errors_before = error_count;
        make_beats(40);
        fork
            send_beats(0, 40);
            receive_beats(0, 40, 1'b1);
        join
        report_test("ordered transfer", errors_before);
    endtask

    task automatic test_back_pressure();
        int        errors_before;
        int        accepted;
        int        low_cycles;
        csr_data_t rdata;
        errors_before = error_count;
        make_beats(24);
        accepted   = 0;
        low_cycles = 0;
        out_ready  = 1'b0;
        @(posedge in_clk);
        #DRIVE_DELAY;
        while (low_cycles < 8 && accepted < beats.size()) begin
            in_data          = beats[accepted].data;
            in_startofpacket = beats[accepted].startofpacket;
            in_endofpacket   = beats[accepted].endofpacket;
            in_valid         = 1'b1;
            if (in_ready) begin
                accepted++;
                low_cycles = 0;
            end else begin
                low_cycles++;
            end
            @(posedge in_clk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;
        check_count("accepted beats", accepted, 17);
        csr_read(1'b1, CSR_FILL_LEVEL, rdata);
        check_csr("out_csr_readdata", rdata, 32'd17);
        csr_read(1'b0, CSR_FILL_LEVEL, rdata);
        check_csr("in_csr_readdata", rdata, 32'd16);
        receive_beats(0, accepted, 1'b0);
        report_test("back-pressure", errors_before);
    endtask

    task automatic test_csr();
        int        errors_before;
        csr_data_t rdata;
        errors_before = error_count;
        csr_write(1'b0, CSR_THRESHOLD, 32'hab00_0005);
        csr_read(1'b0, CSR_THRESHOLD, rdata);
        check_csr("in_csr_readdata", rdata, 32'h0000_0005);
        csr_write(1'b1, CSR_THRESHOLD, 32'hff12_3456);
        csr_read(1'b1, CSR_THRESHOLD, rdata);
        check_csr("out_csr_readdata", rdata, 32'h0012_3456);
        // Park the read data on the fill level, 0 with the FIFO drained
        csr_read(1'b0, CSR_FILL_LEVEL, rdata);
        check_csr("in_csr_readdata", rdata, 32'h0);
        // Read and write together, read data must keep the old value
        csr_access(1'b0, 1'b1, 1'b1, CSR_THRESHOLD, 32'h0000_0009, rdata);
        check_csr("in_csr_readdata", rdata, 32'h0);
        csr_read(1'b0, CSR_THRESHOLD, rdata);
        check_csr("in_csr_readdata", rdata, 32'h0000_0009);
        report_test("CSR access", errors_before);
    endtask

    task automatic test_status();
        int errors_before;
        errors_before = error_count;
        csr_write(1'b0, CSR_THRESHOLD, 32'd4);
        csr_write(1'b1, CSR_THRESHOLD, 32'd2);
        check_bit("almost_full_valid", almost_full_valid, 1'b1);
        check_bit("almost_empty_valid", almost_empty_valid, 1'b1);
        make_beats(6);
        out_ready = 1'b0;
        send_beats(0, 6);
        settle();
        check_bit("almost_full_data", almost_full_data, 1'b1);
        check_bit("almost_empty_data", almost_empty_data, 1'b0);
        receive_beats(0, 6, 1'b0);
        settle();
        check_bit("almost_full_data", almost_full_data, 1'b0);
        check_bit("almost_empty_data", almost_empty_data, 1'b1);
        report_test("status", errors_before);
    endtask

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge in_clk);
            cycle_count++;
        end
        $display("Timeout after %0d in_clk cycles, a test never completed", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        in_clk            = 1'b0;
        out_clk           = 1'b0;
        in_reset_n        = 1'b0;
        out_reset_n       = 1'b0;
        in_data           = '0;
        in_valid          = 1'b0;
        in_startofpacket  = 1'b0;
        in_endofpacket    = 1'b0;
        out_ready         = 1'b0;
        in_csr_address    = 1'b0;
        in_csr_read       = 1'b0;
        in_csr_write      = 1'b0;
        in_csr_writedata  = '0;
        out_csr_address   = 1'b0;
        out_csr_read      = 1'b0;
        out_csr_write     = 1'b0;
        out_csr_writedata = '0;
        rng_state         = SEED;
        error_count       = 0;
        check_count_total = 0;
        tests_run         = 0;

        test_reset_values();
        test_ordered_transfer();
        test_back_pressure();
        test_csr();
        test_status();

        error_count += dcfifo_top_i.dcfifo_assertions_i.failures;
        $display("Tests: %0d, checks: %0d, errors: %0d",
                 tests_run, check_count_total, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hdl/dcfifo_pkg.sv
hdl/dcfifo_csr_if.sv
hdl/dcfifo_ptr_sync.sv
hdl/dcfifo_ram.sv
hdl/dcfifo_write_ctrl.sv
hdl/dcfifo_read_ctrl.sv
hdl/dcfifo_level_csr.sv
hdl/dcfifo_top.sv
test/dcfifo_assertions.sv
test/dcfifo_tb.sv

//--- Bender.yml
package:
  name: dcfifo

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/dcfifo_pkg.sv
      - hdl/dcfifo_csr_if.sv
      - hdl/dcfifo_ptr_sync.sv
      - hdl/dcfifo_ram.sv
      - hdl/dcfifo_write_ctrl.sv
      - hdl/dcfifo_read_ctrl.sv
      - hdl/dcfifo_level_csr.sv
      - hdl/dcfifo_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/dcfifo_assertions.sv
      - test/dcfifo_tb.sv
